/* common/pkt_chk_pkg.sv */
// shared widths, register map and table word layout for the packet checker
// per-port store window is 0x100 bytes, so at most 4 ports and 64 table words per port
package pkt_chk_pkg;

    // stream beat and apb word, fixed at 4 bytes
    localparam int DATA_BYTES = 4;
    localparam int BLEN_W = 16;
    localparam int CNT_W = 16;
    localparam int ADDR_W = 16;

    // global control, bit 0 enable, bit 1 clear counters (self-clearing)
    localparam logic [ADDR_W-1:0] REG_CTRL = 16'h000;
    localparam int CTRL_EN_BIT = 0;
    localparam int CTRL_CLR_BIT = 1;

    // port p lives at REG_PORT_BASE * (p + 1)
    localparam logic [ADDR_W-1:0] REG_PORT_BASE = 16'h100;
    localparam logic [ADDR_W-1:0] OFS_PASS = 16'h000;
    localparam logic [ADDR_W-1:0] OFS_FAIL = 16'h004;
    localparam logic [ADDR_W-1:0] OFS_RXCNT = 16'h008;
    // table words, one per 4 bytes from here
    localparam logic [ADDR_W-1:0] OFS_STORE = 16'h400;
    localparam logic [ADDR_W-1:0] STORE_SPAN = 16'h100;

    // header view of entry 0 of a slot
    typedef struct packed {
        logic valid;
        logic [30-BLEN_W:0] rsvd;
        logic [BLEN_W-1:0] blen;
    } store_hdr_t;

    // one table word, header or four data bytes (byte 0 low)
    typedef union packed {
        logic [DATA_BYTES-1:0][7:0] data;
        store_hdr_t hdr;
    } store_word_u;

    function automatic logic [ADDR_W-1:0] port_base(input int port);
        return ADDR_W'(REG_PORT_BASE * (port + 1));
    endfunction

    // header word plus MTU_WORDS data words per slot
    function automatic int store_depth(input int slots, input int mtu_words);
        return slots * (mtu_words + 1);
    endfunction

    function automatic int store_aw(input int slots, input int mtu_words);
        return $clog2(store_depth(slots, mtu_words));
    endfunction

endpackage

/* pkt_chk/exp_store.sv */
// expected packet table, flop array with combinational reads
// no reset, contents survive counter clears; read addresses must stay below depth
module exp_store #(
    parameter int NUM_SLOTS = 4,
    parameter int MTU_WORDS = 8,
    parameter int NUM_RD = 2,
    localparam int AW = pkt_chk_pkg::store_aw(NUM_SLOTS, MTU_WORDS)
) (
    input  logic                                   clk,
    input  logic                                   st_we,
    input  logic [AW-1:0]                          st_addr,
    input  pkt_chk_pkg::store_word_u               st_wdata,
    input  logic [NUM_RD-1:0][AW-1:0]              rd_addr,
    output pkt_chk_pkg::store_word_u [NUM_RD-1:0]  rd_word
);

    localparam int DEPTH = pkt_chk_pkg::store_depth(NUM_SLOTS, MTU_WORDS);

    // slot s occupies words s*(MTU_WORDS+1) .. s*(MTU_WORDS+1)+MTU_WORDS
    // word 0 of a slot is the header, its valid bit marks a loaded slot
    pkt_chk_pkg::store_word_u mem [DEPTH];

    // single write port from the apb side
    always_ff @(posedge clk) begin
        if (st_we) begin
            mem[st_addr] <= st_wdata;
        end
    end

    // async read so the expected word is there with the beat
    always_comb begin
        for (int i = 0; i < NUM_RD; i++) begin
            rd_word[i] = mem[rd_addr[i]];
        end
    end

endmodule

/* pkt_chk/pkt_chk.sv */
// in-order packet checker for one stream port, slot after slot, wrapping
// never back-pressures inside a packet; tready follows the enable bit only
module pkt_chk #(
    parameter int NUM_SLOTS = 4,
    parameter int MTU_WORDS = 8,
    localparam int AW = pkt_chk_pkg::store_aw(NUM_SLOTS, MTU_WORDS)
) (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic [pkt_chk_pkg::DATA_BYTES*8-1:0]  tdata,
    input  logic [pkt_chk_pkg::DATA_BYTES-1:0]    tkeep,
    input  logic                                  tvalid,
    input  logic                                  tlast,
    output logic                                  tready,
    input  logic                                  chk_en,
    input  logic                                  cnt_clr,
    input  logic                                  st_we,
    input  logic [AW-1:0]                         st_addr,
    input  pkt_chk_pkg::store_word_u              st_wdata,
    output logic                                  pkt_done,
    output logic                                  pkt_ok,
    output logic [pkt_chk_pkg::CNT_W-1:0]         pass_cnt,
    output logic [pkt_chk_pkg::CNT_W-1:0]         fail_cnt,
    output logic [pkt_chk_pkg::CNT_W-1:0]         rx_cnt
);

    localparam int SLOT_W = (NUM_SLOTS > 1) ? $clog2(NUM_SLOTS) : 1;
    localparam int IDX_W = $clog2(MTU_WORDS + 1);
    localparam int KC_W = $clog2(pkt_chk_pkg::DATA_BYTES + 1);

    logic [SLOT_W-1:0]              slot;
    logic [IDX_W-1:0]               word_idx;
    logic [pkt_chk_pkg::BLEN_W-1:0] byte_cnt;
    logic [pkt_chk_pkg::BLEN_W-1:0] fin_cnt;
    logic                           mism;
    logic                           ovr;
    logic [AW-1:0]                  slot_base;
    logic [1:0][AW-1:0]             rd_addr;
    pkt_chk_pkg::store_word_u [1:0] rd_word;
    logic                           beat;
    logic                           cur_over;
    logic                           beat_diff;
    logic                           pkt_bad;
    logic [KC_W-1:0]                keep_cnt;

    assign tready = chk_en;
    assign beat = tvalid & tready;

    // index sits at MTU_WORDS once every data word was consumed
    assign cur_over = (word_idx == IDX_W'(MTU_WORDS));
    assign slot_base = AW'(slot * (MTU_WORDS + 1));

    // port 0 data word, port 1 header of the current slot
    assign rd_addr[0] = slot_base + AW'(cur_over ? word_idx : word_idx + 1'b1);
    assign rd_addr[1] = slot_base;

    exp_store #(
        .NUM_SLOTS (NUM_SLOTS),
        .MTU_WORDS (MTU_WORDS),
        .NUM_RD    (2)
    ) i_exp_store (
        .clk      (clk),
        .st_we    (st_we),
        .st_addr  (st_addr),
        .st_wdata (st_wdata),
        .rd_addr  (rd_addr),
        .rd_word  (rd_word)
    );

    // kept bytes against the data view, plus keep popcount
    always_comb begin
        beat_diff = 1'b0;
        keep_cnt = '0;
        for (int b = 0; b < pkt_chk_pkg::DATA_BYTES; b++) begin
            if (tkeep[b]) begin
                keep_cnt = keep_cnt + 1'b1;
                if (tdata[b*8 +: 8] != rd_word[0].data[b]) begin
                    beat_diff = 1'b1;
                end
            end
        end
    end

    assign fin_cnt = byte_cnt + pkt_chk_pkg::BLEN_W'(keep_cnt);

    // verdict terms, only used on the tlast beat
    assign pkt_bad = mism | beat_diff | ovr | cur_over | ~rd_word[1].hdr.valid |
                     (fin_cnt != rd_word[1].hdr.blen);

    always_ff @(posedge clk) begin
        if (rst) begin
            slot <= '0;
            word_idx <= '0;
            byte_cnt <= '0;
            mism <= 1'b0;
            ovr <= 1'b0;
            pkt_done <= 1'b0;
            pkt_ok <= 1'b0;
        end else begin
            pkt_done <= beat & tlast;
            pkt_ok <= beat & tlast & ~pkt_bad;
            if (beat && tlast) begin
                // next packet may start right away
                word_idx <= '0;
                byte_cnt <= '0;
                mism <= 1'b0;
                ovr <= 1'b0;
                slot <= (slot == SLOT_W'(NUM_SLOTS - 1)) ? '0 : slot + 1'b1;
            end else if (beat) begin
                byte_cnt <= fin_cnt;
                mism <= mism | beat_diff;
                // sticky once a beat lands past the table
                ovr <= ovr | cur_over;
                if (!cur_over) begin
                    word_idx <= word_idx + 1'b1;
                end
            end
        end
    end

    // counters step with the verdict edge, clear takes priority
    always_ff @(posedge clk) begin
        if (rst || cnt_clr) begin
            pass_cnt <= '0;
            fail_cnt <= '0;
            rx_cnt <= '0;
        end else if (beat && tlast) begin
            rx_cnt <= rx_cnt + 1'b1;
            if (pkt_bad) begin
                fail_cnt <= fail_cnt + 1'b1;
            end else begin
                pass_cnt <= pass_cnt + 1'b1;
            end
        end
    end

endmodule

/* hdl/apb_regs.sv */
// zero wait state APB slave, reads return in the access phase
// table contents are write-only over APB, store reads return 0
module apb_regs #(
    parameter int NUM_PORTS = 2,
    parameter int NUM_SLOTS = 4,
    parameter int MTU_WORDS = 8,
    localparam int AW = pkt_chk_pkg::store_aw(NUM_SLOTS, MTU_WORDS)
) (
    input  logic                                      clk,
    input  logic                                      rst,
    input  logic [pkt_chk_pkg::ADDR_W-1:0]            paddr,
    input  logic                                      psel,
    input  logic                                      penable,
    input  logic                                      pwrite,
    input  logic [31:0]                               pwdata,
    output logic [31:0]                               prdata,
    output logic                                      pready,
    output logic                                      pslverr,
    input  logic [NUM_PORTS*pkt_chk_pkg::CNT_W-1:0]   pass_cnt,
    input  logic [NUM_PORTS*pkt_chk_pkg::CNT_W-1:0]   fail_cnt,
    input  logic [NUM_PORTS*pkt_chk_pkg::CNT_W-1:0]   rx_cnt,
    output logic                                      chk_en,
    output logic                                      cnt_clr,
    output logic [NUM_PORTS-1:0]                      st_we,
    output logic [AW-1:0]                             st_addr,
    output pkt_chk_pkg::store_word_u                  st_wdata
);

    localparam int DEPTH = pkt_chk_pkg::store_depth(NUM_SLOTS, MTU_WORDS);

    logic                 acc;
    logic                 wr_ok;
    logic                 ctrl_hit;
    logic                 cnt_hit;
    logic                 st_oob;
    logic                 unmapped;
    logic [NUM_PORTS-1:0] st_hit;
    logic [31:0]          rd_mux;

    // access phase, no wait states
    assign acc = psel & penable;
    assign pready = 1'b1;

    // address decode over all port windows
    always_comb begin
        logic [pkt_chk_pkg::ADDR_W-1:0] off;
        logic [pkt_chk_pkg::ADDR_W-1:0] sidx;
        ctrl_hit = (paddr == pkt_chk_pkg::REG_CTRL);
        cnt_hit = 1'b0;
        st_hit = '0;
        st_oob = 1'b0;
        st_addr = '0;
        rd_mux = '0;
        off = '0;
        sidx = '0;
        if (ctrl_hit) begin
            // clear bit always reads 0
            rd_mux[pkt_chk_pkg::CTRL_EN_BIT] = chk_en;
        end
        for (int p = 0; p < NUM_PORTS; p++) begin
            // wraps to a large value below the port base
            off = paddr - pkt_chk_pkg::port_base(p);
            if (off == pkt_chk_pkg::OFS_PASS) begin
                cnt_hit = 1'b1;
                rd_mux = 32'(pass_cnt[p*pkt_chk_pkg::CNT_W +: pkt_chk_pkg::CNT_W]);
            end
            if (off == pkt_chk_pkg::OFS_FAIL) begin
                cnt_hit = 1'b1;
                rd_mux = 32'(fail_cnt[p*pkt_chk_pkg::CNT_W +: pkt_chk_pkg::CNT_W]);
            end
            if (off == pkt_chk_pkg::OFS_RXCNT) begin
                cnt_hit = 1'b1;
                rd_mux = 32'(rx_cnt[p*pkt_chk_pkg::CNT_W +: pkt_chk_pkg::CNT_W]);
            end
            // store window, word aligned only
            if (off >= pkt_chk_pkg::OFS_STORE &&
                off < pkt_chk_pkg::OFS_STORE + pkt_chk_pkg::STORE_SPAN &&
                off[1:0] == 2'b00) begin
                sidx = (off - pkt_chk_pkg::OFS_STORE) >> 2;
                if (int'(sidx) < DEPTH) begin
                    st_hit[p] = 1'b1;
                    st_addr = AW'(sidx);
                end else begin
                    // past the end of the table
                    st_oob = 1'b1;
                end
            end
        end
    end

    assign unmapped = ~(ctrl_hit | cnt_hit | (|st_hit) | st_oob);

    // counters are read-only
    assign pslverr = acc & (unmapped | st_oob | (pwrite & cnt_hit));
    assign wr_ok = acc & pwrite & ~pslverr;
    assign prdata = (acc && !pwrite && !pslverr) ? rd_mux : '0;

    // table write lands on the edge that ends the access phase
    assign st_we = wr_ok ? st_hit : '0;
    assign st_wdata = pwdata;

    always_ff @(posedge clk) begin
        if (rst) begin
            chk_en <= 1'b0;
            cnt_clr <= 1'b0;
        end else begin
            // one cycle pulse per write with bit 1 set
            cnt_clr <= wr_ok & ctrl_hit & pwdata[pkt_chk_pkg::CTRL_CLR_BIT];
            if (wr_ok && ctrl_hit) begin
                chk_en <= pwdata[pkt_chk_pkg::CTRL_EN_BIT];
            end
        end
    end

endmodule

/* hdl/pkt_chk_array.sv */
// multi-port stream packet checker, one checker per port plus an APB register block
// stream ports are packed per port, port 0 in the low bits
module pkt_chk_array #(
    parameter int NUM_PORTS = 2,
    parameter int NUM_SLOTS = 4,
    parameter int MTU_WORDS = 8
) (
    input  logic                                          clk,
    input  logic                                          rst,
    input  logic [pkt_chk_pkg::ADDR_W-1:0]                paddr,
    input  logic                                          psel,
    input  logic                                          penable,
    input  logic                                          pwrite,
    input  logic [31:0]                                   pwdata,
    output logic [31:0]                                   prdata,
    output logic                                          pready,
    output logic                                          pslverr,
    input  logic [NUM_PORTS*pkt_chk_pkg::DATA_BYTES*8-1:0] s_tdata,
    input  logic [NUM_PORTS*pkt_chk_pkg::DATA_BYTES-1:0]  s_tkeep,
    input  logic [NUM_PORTS-1:0]                          s_tvalid,
    input  logic [NUM_PORTS-1:0]                          s_tlast,
    output logic [NUM_PORTS-1:0]                          s_tready,
    output logic [NUM_PORTS-1:0]                          pkt_done,
    output logic [NUM_PORTS-1:0]                          pkt_ok
);

    localparam int AW = pkt_chk_pkg::store_aw(NUM_SLOTS, MTU_WORDS);
    localparam int DW = pkt_chk_pkg::DATA_BYTES * 8;
    localparam int KW = pkt_chk_pkg::DATA_BYTES;
    localparam int CW = pkt_chk_pkg::CNT_W;

    logic                     chk_en;
    logic                     cnt_clr;
    logic [NUM_PORTS-1:0]     st_we;
    logic [AW-1:0]            st_addr;
    pkt_chk_pkg::store_word_u st_wdata;
    logic [NUM_PORTS*CW-1:0]  pass_cnt;
    logic [NUM_PORTS*CW-1:0]  fail_cnt;
    logic [NUM_PORTS*CW-1:0]  rx_cnt;

    apb_regs #(
        .NUM_PORTS (NUM_PORTS),
        .NUM_SLOTS (NUM_SLOTS),
        .MTU_WORDS (MTU_WORDS)
    ) i_apb_regs (
        .clk      (clk),
        .rst      (rst),
        .paddr    (paddr),
        .psel     (psel),
        .penable  (penable),
        .pwrite   (pwrite),
        .pwdata   (pwdata),
        .prdata   (prdata),
        .pready   (pready),
        .pslverr  (pslverr),
        .pass_cnt (pass_cnt),
        .fail_cnt (fail_cnt),
        .rx_cnt   (rx_cnt),
        .chk_en   (chk_en),
        .cnt_clr  (cnt_clr),
        .st_we    (st_we),
        .st_addr  (st_addr),
        .st_wdata (st_wdata)
    );

    // one checker per port, shared write bus with per-port strobe
    for (genvar p = 0; p < NUM_PORTS; p++) begin : g_port
        pkt_chk #(
            .NUM_SLOTS (NUM_SLOTS),
            .MTU_WORDS (MTU_WORDS)
        ) i_pkt_chk (
            .clk      (clk),
            .rst      (rst),
            .tdata    (s_tdata[p*DW +: DW]),
            .tkeep    (s_tkeep[p*KW +: KW]),
            .tvalid   (s_tvalid[p]),
            .tlast    (s_tlast[p]),
            .tready   (s_tready[p]),
            .chk_en   (chk_en),
            .cnt_clr  (cnt_clr),
            .st_we    (st_we[p]),
            .st_addr  (st_addr),
            .st_wdata (st_wdata),
            .pkt_done (pkt_done[p]),
            .pkt_ok   (pkt_ok[p]),
            .pass_cnt (pass_cnt[p*CW +: CW]),
            .fail_cnt (fail_cnt[p*CW +: CW]),
            .rx_cnt   (rx_cnt[p*CW +: CW])
        );
    end

endmodule

/* testbench/pkt_chk_array_properties.sv */
// concurrent checks bound into every pkt_chk_array instance
// chk_en and cnt_clr are taken from the top level's internal nets
module pkt_chk_array_properties #(
    parameter int NUM_PORTS = 2
) (
    input logic                           clk,
    input logic                           rst,
    input logic [pkt_chk_pkg::ADDR_W-1:0] paddr,
    input logic                           psel,
    input logic                           penable,
    input logic                           pwrite,
    input logic [31:0]                    pwdata,
    input logic                           pready,
    input logic                           chk_en,
    input logic                           cnt_clr,
    input logic [NUM_PORTS-1:0]           s_tvalid,
    input logic [NUM_PORTS-1:0]           s_tlast,
    input logic [NUM_PORTS-1:0]           s_tready,
    input logic [NUM_PORTS-1:0]           pkt_done
);
    timeunit 1ns;
    timeprecision 1ps;

    logic [NUM_PORTS-1:0] last_hs;
    logic                 en_written;
    // failed assertions, summed into the end of test count
    int                   fail_count = 0;

    // tlast handshake per port
    assign last_hs = s_tvalid & s_tready & s_tlast;

    // enable bit as last written over APB
    always_ff @(posedge clk) begin
        if (rst) begin
            en_written <= 1'b0;
        end else if (psel && penable && pwrite && paddr == pkt_chk_pkg::REG_CTRL) begin
            en_written <= pwdata[pkt_chk_pkg::CTRL_EN_BIT];
        end
    end

    // quiet outputs right after reset
    a_reset_state: assert property (@(posedge clk)
        rst |=> (s_tready == '0 && pkt_done == '0 && !chk_en))
        else begin
            fail_count++;
            $error("stream outputs not idle after reset");
        end

    // no beat accepted before enable was written
    a_tready_en: assert property (@(posedge clk) disable iff (rst)
        (|s_tready) |-> en_written)
        else begin
            fail_count++;
            $error("s_tready high without enable written");
        end

    // verdict exactly one cycle after tlast handshake
    a_done_timing: assert property (@(posedge clk) disable iff (rst)
        pkt_done == $past(last_hs))
        else begin
            fail_count++;
            $error("pkt_done not one cycle after tlast handshake");
        end

    // no wait states
    a_pready: assert property (@(posedge clk) disable iff (rst)
        (psel && penable) |-> pready)
        else begin
            fail_count++;
            $error("pready low in APB access phase");
        end

    a_clr_pulse: assert property (@(posedge clk) disable iff (rst)
        cnt_clr |=> !cnt_clr)
        else begin
            fail_count++;
            $error("cnt_clr longer than one cycle");
        end

endmodule

bind pkt_chk_array pkt_chk_array_properties #(
    .NUM_PORTS (NUM_PORTS)
) i_pkt_chk_array_properties (
    .clk      (clk),
    .rst      (rst),
    .paddr    (paddr),
    .psel     (psel),
    .penable  (penable),
    .pwrite   (pwrite),
    .pwdata   (pwdata),
    .pready   (pready),
    .chk_en   (chk_en),
    .cnt_clr  (cnt_clr),
    .s_tvalid (s_tvalid),
    .s_tlast  (s_tlast),
    .s_tready (s_tready),
    .pkt_done (pkt_done)
);

/* testbench/pkt_chk_array_tb.sv */
// testbench for pkt_chk_array at default parameters, 2 ports, 4 slots, 8 word MTU
// keeps its own copy of every table and derives each expected verdict from it
module pkt_chk_array_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NP = 2;
    localparam int NS = 4;
    localparam int MTU = 8;
    localparam int LIMIT = 100;

    logic             clk;
    logic             rst;
    logic [15:0]      paddr;
    logic             psel;
    logic             penable;
    logic             pwrite;
    logic [31:0]      pwdata;
    logic [31:0]      prdata;
    logic             pready;
    logic             pslverr;
    logic [NP*32-1:0] s_tdata;
    logic [NP*4-1:0]  s_tkeep;
    logic [NP-1:0]    s_tvalid;
    logic [NP-1:0]    s_tlast;
    logic [NP-1:0]    s_tready;
    logic [NP-1:0]    pkt_done;
    logic [NP-1:0]    pkt_ok;

    // reference copy of the tables, slot pointers and counters
    logic [7:0] tbl [NP][NS][MTU*4];
    int         tlen [NP][NS];
    bit         tvld [NP][NS];
    int         nxt [NP];
    int         n_pass [NP];
    int         n_fail [NP];
    int         n_rx [NP];
    // bytes of the packet about to be sent
    logic [7:0] pkt [$];
    int         seed = 58871;
    int         errors = 0;
    int         tests = 0;
    int         mark = 0;

    pkt_chk_array i_pkt_chk_array (.*);

    always #10 clk = ~clk;

    task automatic timeout_fail(input string what);
        $display("timeout: %s did not happen within %0d cycles at %0t", what, LIMIT, $time);
        $display("RESULT: FAIL");
        $finish;
    endtask

    task automatic expect_eq(input string what, input int got, input int exp);
        if (got != exp) begin
            errors++;
            $display("ERR %0t: %s read %0d expected %0d", $time, what, got, exp);
        end
    endtask

    // one APB transfer, starts and ends 2 ns after a rising edge
    task automatic apb_access(input bit wr, input int addr, input logic [31:0] wd,
                              output logic [31:0] rd, output bit err);
        int cyc;
        paddr = 16'(addr);
        pwrite = wr;
        pwdata = wd;
        psel = 1'b1;
        penable = 1'b0;
        @(posedge clk);
        #2;
        penable = 1'b1;
        cyc = 0;
        @(negedge clk);
        while (!pready) begin
            cyc++;
            if (cyc > LIMIT) timeout_fail("APB pready");
            @(negedge clk);
        end
        // sampled mid access phase, away from the edges
        rd = prdata;
        err = pslverr;
        @(posedge clk);
        #2;
        psel = 1'b0;
        penable = 1'b0;
    endtask

    task automatic verify_counters(input int p);
        logic [31:0] rd;
        bit err;
        int base;
        base = 'h100 * (p + 1);
        apb_access(1'b0, base, '0, rd, err);
        expect_eq($sformatf("port %0d pass_cnt", p), int'(rd), n_pass[p]);
        apb_access(1'b0, base + 4, '0, rd, err);
        expect_eq($sformatf("port %0d fail_cnt", p), int'(rd), n_fail[p]);
        apb_access(1'b0, base + 8, '0, rd, err);
        expect_eq($sformatf("port %0d rx_cnt", p), int'(rd), n_rx[p]);
    endtask

    // fresh random bytes into a slot, header then all data words
    task automatic load_slot(input int p, input int s, input int len, input bit vld);
        logic [31:0] rd;
        bit err;
        int a;
        a = 'h100 * (p + 1) + 'h400 + 4 * s * (MTU + 1);
        tlen[p][s] = len;
        tvld[p][s] = vld;
        for (int i = 0; i < MTU * 4; i++) begin
            tbl[p][s][i] = 8'($random(seed));
        end
        // valid in bit 31, byte length low
        apb_access(1'b1, a, {vld, 15'd0, 16'(len)}, rd, err);
        expect_eq("header write pslverr", int'(err), 0);
        for (int w = 0; w < MTU; w++) begin
            apb_access(1'b1, a + 4 * (w + 1),
                       {tbl[p][s][4*w+3], tbl[p][s][4*w+2], tbl[p][s][4*w+1], tbl[p][s][4*w]},
                       rd, err);
        end
    endtask

    // copy of a slot, longer packets padded with random bytes
    task automatic build_pkt(input int p, input int s, input int len, input int flip);
        pkt.delete();
        for (int i = 0; i < len; i++) begin
            pkt.push_back((i < MTU * 4) ? tbl[p][s][i] : 8'($random(seed)));
        end
        if (flip >= 0) pkt[flip] = pkt[flip] ^ 8'h5a;
    endtask

    task automatic send_pkt(input int p);
        int s;
        int nb;
        int gap;
        int cyc;
        bit ok;
        s = nxt[p];
        // pass needs a valid header, equal length, no overrun and equal bytes
        ok = tvld[p][s] && pkt.size() == tlen[p][s] && pkt.size() <= MTU * 4;
        for (int i = 0; i < pkt.size() && i < MTU * 4; i++) begin
            if (pkt[i] != tbl[p][s][i]) ok = 1'b0;
        end
        for (int b = 0; b < pkt.size(); b += 4) begin
            // tvalid gap of up to 2 cycles before some beats
            gap = $unsigned($random(seed)) % 6;
            s_tvalid[p] = 1'b0;
            repeat ((gap > 2) ? 0 : gap) begin
                @(posedge clk);
                #2;
            end
            nb = (pkt.size() - b > 4) ? 4 : pkt.size() - b;
            for (int k = 0; k < 4; k++) begin
                s_tdata[p*32+k*8 +: 8] = (k < nb) ? pkt[b+k] : 8'h00;
                s_tkeep[p*4+k] = (k < nb);
            end
            s_tlast[p] = (b + 4 >= pkt.size());
            s_tvalid[p] = 1'b1;
            cyc = 0;
            @(negedge clk);
            while (!s_tready[p]) begin
                cyc++;
                if (cyc > LIMIT) timeout_fail("stream tready");
                @(negedge clk);
            end
            // beat moves on this edge
            @(posedge clk);
            #2;
        end
        s_tvalid[p] = 1'b0;
        s_tlast[p] = 1'b0;
        cyc = 0;
        @(negedge clk);
        while (!pkt_done[p]) begin
            cyc++;
            if (cyc > LIMIT) timeout_fail("pkt_done");
            @(negedge clk);
        end
        expect_eq($sformatf("port %0d slot %0d pkt_ok", p, s), int'(pkt_ok[p]), int'(ok));
        n_rx[p]++;
        if (ok) n_pass[p]++;
        else n_fail[p]++;
        nxt[p] = (s + 1) % NS;
        @(posedge clk);
        #2;
    endtask

    task automatic end_test(input string name);
        tests++;
        $display("test %0d %s: %0d errors", tests, name, errors - mark);
        mark = errors;
    endtask

    initial begin
        logic [31:0] rd;
        bit err;
        clk = 1'b0;
        rst = 1'b1;
        paddr = '0;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        pwdata = '0;
        s_tdata = '0;
        s_tkeep = '0;
        s_tvalid = '0;
        s_tlast = '0;
        repeat (5) @(posedge clk);
        #2;
        rst = 1'b0;

        // reset state, counters at zero, then enable
        @(negedge clk);
        expect_eq("s_tready after reset", int'(s_tready), 0);
        expect_eq("pkt_done after reset", int'(pkt_done), 0);
        @(posedge clk);
        #2;
        verify_counters(0);
        verify_counters(1);
        apb_access(1'b1, 'h000, 32'h1, rd, err);
        @(negedge clk);
        expect_eq("s_tready after enable", int'(s_tready), (1 << NP) - 1);
        @(posedge clk);
        #2;
        end_test("reset and enable");

        // random 1 to 32 byte packets in every slot of both ports
        for (int p = 0; p < NP; p++) begin
            for (int s = 0; s < NS; s++) begin
                load_slot(p, s, 1 + $unsigned($random(seed)) % 32, 1'b1);
            end
        end
        for (int p = 0; p < NP; p++) begin
            for (int s = 0; s < NS; s++) begin
                build_pkt(p, s, tlen[p][s], -1);
                send_pkt(p);
            end
        end
        verify_counters(0);
        verify_counters(1);
        end_test("matching packets");

        // corrupt byte, short, long, overrun, then an unloaded slot
        load_slot(0, 0, 20, 1'b1);
        load_slot(0, 1, 13, 1'b1);
        load_slot(0, 2, 17, 1'b1);
        load_slot(0, 3, 32, 1'b1);
        build_pkt(0, 0, 20, $unsigned($random(seed)) % 20);
        send_pkt(0);
        build_pkt(0, 1, 12, -1);
        send_pkt(0);
        build_pkt(0, 2, 18, -1);
        send_pkt(0);
        build_pkt(0, 3, 36, -1);
        send_pkt(0);
        load_slot(0, 0, 20, 1'b0);
        build_pkt(0, 0, 20, -1);
        send_pkt(0);
        verify_counters(0);
        end_test("mismatches");

        // port 0 wraps past the last slot, port 1 stays idle
        for (int s = 0; s < NS; s++) begin
            load_slot(0, s, 1 + $unsigned($random(seed)) % 32, 1'b1);
        end
        for (int k = 0; k < NS + 2; k++) begin
            build_pkt(0, nxt[0], tlen[0][nxt[0]], -1);
            send_pkt(0);
        end
        verify_counters(0);
        verify_counters(1);
        end_test("slot wrap and port independence");

        // bad addresses and counter writes error out without effect
        apb_access(1'b1, 'h00c, 32'h0, rd, err);
        expect_eq("unmapped write pslverr", int'(err), 1);
        apb_access(1'b1, 'h100, 32'h55, rd, err);
        expect_eq("counter write pslverr", int'(err), 1);
        apb_access(1'b1, 'h500 + 4 * NS * (MTU + 1), 32'h0, rd, err);
        expect_eq("store past end pslverr", int'(err), 1);
        verify_counters(0);
        // clear keeps enable set, tables stay loaded
        apb_access(1'b1, 'h000, 32'h3, rd, err);
        for (int p = 0; p < NP; p++) begin
            n_pass[p] = 0;
            n_fail[p] = 0;
            n_rx[p] = 0;
        end
        verify_counters(0);
        verify_counters(1);
        build_pkt(0, nxt[0], tlen[0][nxt[0]], -1);
        send_pkt(0);
        verify_counters(0);
        end_test("APB errors and counter clear");

        // failed bound assertions count as errors too
        errors += i_pkt_chk_array.i_pkt_chk_array_properties.fail_count;
        $display("tests run %0d, errors %0d", tests, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* flist.f */
common/pkt_chk_pkg.sv
pkt_chk/exp_store.sv
pkt_chk/pkt_chk.sv
hdl/apb_regs.sv
hdl/pkt_chk_array.sv
testbench/pkt_chk_array_properties.sv
testbench/pkt_chk_array_tb.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the packet checker testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module pkt_chk_array_tb -f flist.f -o sim_pkt_chk_array

out=$(./obj_dir/sim_pkt_chk_array 2>&1) || true
echo "$out"
grep -qx "RESULT: PASS" <<< "$out"
